//--- filelist.f
src/rv_pkg.sv
src/decoder.sv
src/exec_unit.sv
src/regfile.sv
src/stage_ctrl.sv
src/mem_port.sv
src/writeback.sv
src/cpu_top.sv
verification/tb_mem.sv
verification/tb_cpu.sv

//--- Makefile
TOP       ?= tb_cpu
FILELIST  ?= filelist.f
SEED_LOG  ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert

PASS_MSG := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(SEED_LOG)
	grep -q "^$(PASS_MSG)$$" $(SEED_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

//--- verification/tb_cpu.sv
module tb_cpu;

    localparam int mem_words  = 256;
    localparam int max_stores = 64;

    logic        clk;
    logic        reset_n;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    logic        mem_valid;
    logic        mem_instr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic [31:0] pc_out;

    logic [31:0] image [mem_words];      // program at 0, data from 0x300
    logic [31:0] exp_addr [max_stores];
    logic [31:0] exp_data [max_stores];
    int          n_prog;
    int          n_exp;
    logic [31:0] next_addr;              // next free result word
    logic [31:0] park_pc;                // address of the final self-jump

    cpu_top DUT (
        .clk(clk), .reset_n(reset_n), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .pc_out(pc_out)
    );

    tb_mem #(.words(mem_words)) u_mem (
        .clk(clk), .reset_n(reset_n), .image(image), .mem_valid(mem_valid),
        .mem_instr(mem_instr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // rv32i encoders
    // ------------------------------------------------------------------
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // sw
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ------------------------------------------------------------------
    // program and expectation builders
    // ------------------------------------------------------------------
    task automatic emit(input logic [31:0] w);
        image[n_prog] = w;
        n_prog++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    // sw rs2 to the next result word, x0 as base
    task automatic store_word(input logic [4:0] rs2, input logic [31:0] value);
        emit(s_type(next_addr[11:0], rs2, 5'd0));
        expect_store(next_addr, value);
        next_addr += 32'd4;
    endtask

    task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [31:0] value);
        emit(r_type(f7, rs2, rs1, f3, 5'd3));      // result in x3
        store_word(5'd3, value);
    endtask

    task automatic alu_imm(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rs1,
                           input logic [31:0] value);
        emit(i_type(imm, rs1, f3, 5'd3, 7'b0010011));
        store_word(5'd3, value);
    endtask

    // branch over a not-taken marker (x9 = 1) to a taken marker (x10 = 2)
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic taken);
        emit(b_type(13'd12, rs2, rs1, f3));
        emit(s_type(next_addr[11:0], 5'd9, 5'd0));
        emit(j_type(21'd8, 5'd0));                  // skip the taken marker
        emit(s_type(next_addr[11:0], 5'd10, 5'd0));
        expect_store(next_addr, taken ? 32'd2 : 32'd1);
        next_addr += 32'd4;
    endtask

    task automatic build_program();
        logic [31:0] here;
        logic [31:0] slot;
        emit(i_type(12'hff9, 5'd0, 3'b000, 5'd1, 7'b0010011));   // x1 = -7
        emit(i_type(12'h00c, 5'd0, 3'b000, 5'd2, 7'b0010011));   // x2 = 12
        emit(i_type(12'h003, 5'd0, 3'b000, 5'd4, 7'b0010011));   // x4 = 3
        alu_reg(7'h00, 3'b000, 5'd1, 5'd2, 32'h0000_0005);   // add
        alu_reg(7'h20, 3'b000, 5'd1, 5'd2, 32'hffff_ffed);   // sub
        alu_reg(7'h00, 3'b111, 5'd1, 5'd2, 32'h0000_0008);   // and
        alu_reg(7'h00, 3'b110, 5'd1, 5'd2, 32'hffff_fffd);   // or
        alu_reg(7'h00, 3'b100, 5'd1, 5'd2, 32'hffff_fff5);   // xor
        alu_reg(7'h00, 3'b010, 5'd1, 5'd2, 32'h0000_0001);   // slt, signed
        alu_reg(7'h00, 3'b011, 5'd1, 5'd2, 32'h0000_0000);   // sltu, -7 is huge
        alu_reg(7'h00, 3'b001, 5'd2, 5'd4, 32'h0000_0060);   // sll
        alu_reg(7'h00, 3'b101, 5'd1, 5'd4, 32'h1fff_ffff);   // srl
        alu_reg(7'h20, 3'b101, 5'd1, 5'd4, 32'hffff_ffff);   // sra
        alu_imm(3'b000, 12'h064, 5'd1, 32'h0000_005d);       // addi
        alu_imm(3'b111, 12'h006, 5'd2, 32'h0000_0004);       // andi
        alu_imm(3'b110, 12'h003, 5'd2, 32'h0000_000f);       // ori
        alu_imm(3'b100, 12'hfff, 5'd1, 32'h0000_0006);       // xori -1
        alu_imm(3'b010, 12'hffa, 5'd1, 32'h0000_0001);       // slti -6
        alu_imm(3'b011, 12'h00d, 5'd2, 32'h0000_0001);       // sltiu
        alu_imm(3'b011, 12'h005, 5'd1, 32'h0000_0000);
        alu_imm(3'b001, 12'h004, 5'd2, 32'h0000_00c0);       // slli
        alu_imm(3'b101, 12'h01c, 5'd1, 32'h0000_000f);       // srli 28
        alu_imm(3'b101, 12'h401, 5'd1, 32'hffff_fffc);       // srai 1 on -7
        emit(u_type(20'h12345, 5'd5, 7'b0110111));           // lui
        store_word(5'd5, 32'h1234_5000);
        here = n_prog * 4;
        emit(u_type(20'h00001, 5'd5, 7'b0010111));           // auipc
        store_word(5'd5, 32'h0000_1000 + here);
        // store, load back, store again
        emit(u_type(20'habcde, 5'd6, 7'b0110111));
        emit(i_type(12'h123, 5'd6, 3'b000, 5'd6, 7'b0010011));
        slot = next_addr;
        store_word(5'd6, 32'habcd_e123);
        emit(i_type(slot[11:0], 5'd0, 3'b010, 5'd7, 7'b0000011));   // lw x7
        store_word(5'd7, 32'habcd_e123);
        emit(i_type(12'h037, 5'd0, 3'b000, 5'd0, 7'b0010011));      // write to x0
        alu_reg(7'h00, 3'b000, 5'd0, 5'd2, 32'h0000_000c);
        store_word(5'd0, 32'h0000_0000);
        // branch markers and a second 12
        emit(i_type(12'h001, 5'd0, 3'b000, 5'd9, 7'b0010011));
        emit(i_type(12'h002, 5'd0, 3'b000, 5'd10, 7'b0010011));
        emit(i_type(12'h00c, 5'd0, 3'b000, 5'd11, 7'b0010011));
        branch_case(3'b000, 5'd2, 5'd11, 1'b1);   // beq
        branch_case(3'b000, 5'd1, 5'd2, 1'b0);
        branch_case(3'b001, 5'd1, 5'd2, 1'b1);    // bne
        branch_case(3'b001, 5'd2, 5'd11, 1'b0);
        branch_case(3'b100, 5'd1, 5'd2, 1'b1);    // blt
        branch_case(3'b100, 5'd2, 5'd1, 1'b0);
        branch_case(3'b101, 5'd2, 5'd1, 1'b1);    // bge
        branch_case(3'b101, 5'd1, 5'd2, 1'b0);
        branch_case(3'b101, 5'd2, 5'd11, 1'b1);   // bge on equal
        branch_case(3'b110, 5'd2, 5'd1, 1'b1);    // bltu
        branch_case(3'b110, 5'd1, 5'd2, 1'b0);
        branch_case(3'b111, 5'd1, 5'd2, 1'b1);    // bgeu
        branch_case(3'b111, 5'd2, 5'd1, 1'b0);
        // jal skips one word, the skipped store would land at 0x3fc
        here = n_prog * 4;
        emit(j_type(21'd8, 5'd12));
        emit(s_type(12'h3fc, 5'd10, 5'd0));
        store_word(5'd12, here + 32'd4);
        // jalr to base + 13, bit 0 cleared gives base + 12
        here = n_prog * 4;
        emit(u_type(20'h00000, 5'd13, 7'b0010111));
        emit(i_type(12'd13, 5'd13, 3'b000, 5'd14, 7'b1100111));
        emit(s_type(12'h3fc, 5'd10, 5'd0));
        store_word(5'd14, here + 32'd8);
        park_pc = n_prog * 4;
        emit(j_type(21'd0, 5'd0));                // park
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("mismatch at time %0t: %s, got %h, expected %h", $time, what, got,
                     expected);
            $display("=== FAIL ===");
            $fatal(1, "check failed");
        end
    endtask

    // fetches live below the program end, data from 0x300 up
    always @(negedge clk) begin
        if (reset_n && mem_valid && mem_ready)
            check_equal({31'b0, mem_instr}, {31'b0, mem_addr < n_prog * 4}, "mem_instr flag");
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin : main
        reset_n   = 1'b0;
        n_prog    = 0;
        n_exp     = 0;
        next_addr = 32'h0000_0300;
        for (int i = 0; i < mem_words; i++) begin
            image[i] = 32'h0;                     // opcode 0 decodes as a no-op
        end
        build_program();
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        for (int i = 0; i < n_exp; i++) begin
            while (u_mem.log_count <= i) @(negedge clk);
            check_equal(u_mem.log_addr[i], exp_addr[i], "store address");
            check_equal(u_mem.log_data[i], exp_data[i], "store data");
        end
        repeat (100) @(negedge clk);              // cpu parks, no more stores
        check_equal(u_mem.log_count, n_exp, "store count");
        check_equal(pc_out, park_pc, "parked pc");
        $display("=== PASS ===");
        $finish;
    end

    // worst case per instruction is well under 32 cycles
    initial begin : watchdog
        #1;
        repeat (8 + 100 + n_prog * 8 * 4) @(posedge clk);
        $display("timeout: expected stores did not all appear");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired, pc %h", pc_out);
    end

endmodule

//--- verification/tb_mem.sv
module tb_mem #(
    parameter int words = 256
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] image [words],    // program image, copied in during reset
    input  logic        mem_valid,
    input  logic        mem_instr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_wstrb,
    output logic        mem_ready,
    output logic [31:0] mem_rdata
);

    logic [31:0] mem [words];
    logic [31:0] log_addr [64];     // completed stores, in order
    logic [31:0] log_data [64];
    int          log_count;
    logic [31:0] rand_state;
    logic [1:0]  wait_cnt;          // cycles left before the next answer
    logic [$clog2(words)-1:0] idx;

    assign idx = mem_addr[$clog2(words)+1:2];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
    end

    always @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < words; i++) begin
                mem[i] <= image[i];
            end
            mem_ready  <= 1'b0;
            rand_state <= 32'd70;          // fixed seed
            wait_cnt   <= 2'd0;
            log_count  <= 0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;             // handshake completes on this edge
            if (mem_wstrb != 4'b0000 && !mem_instr) begin
                mem[idx] <= mem_wdata;
                if (log_count < 64) begin
                    log_addr[log_count[5:0]] <= mem_addr;
                    log_data[log_count[5:0]] <= mem_wdata;
                end
                log_count <= log_count + 1;
            end
        end else if (mem_valid) begin
            if (wait_cnt == 2'd0) begin
                mem_ready  <= 1'b1;
                mem_rdata  <= mem[idx];    // read data, ignored for stores
                rand_state <= xorshift32(rand_state);
                wait_cnt   <= rand_state[1:0];   // 0 to 3 cycles next time
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

//--- src/cpu_top.sv
module cpu_top (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          mem_ready,
    input  rv_pkg::word_t mem_rdata,
    output logic          mem_valid,
    output logic          mem_instr,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic [3:0]    mem_wstrb,
    output rv_pkg::word_t pc_out
);

    rv_pkg::stage_t stage;
    rv_pkg::ctrl_t  ctrl;
    rv_pkg::word_t  instr, imm, pc, load_data;
    rv_pkg::word_t  rs1_data, rs2_data, alu_result, rd_data;
    logic           xfer_done, take_branch, rd_we;

    // ------------------------------------------------------------------
    // decode and execute, all combinational
    // ------------------------------------------------------------------
    decoder u_decoder (.instr(instr), .ctrl(ctrl), .imm(imm));

    regfile u_regfile (.clk(clk), .reset_n(reset_n), .rs1_addr(instr[19:15]),
        .rs2_addr(instr[24:20]), .rd_addr(instr[11:7]), .rd_we(rd_we), .rd_data(rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data));

    exec_unit u_exec (.ctrl(ctrl), .pc(pc), .imm(imm), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .funct3(instr[14:12]), .alu_result(alu_result),
        .take_branch(take_branch));

    // ------------------------------------------------------------------
    // sequencing, memory port, writeback
    // ------------------------------------------------------------------
    stage_ctrl u_stage (.clk(clk), .reset_n(reset_n), .mem_ready(mem_ready), .ctrl(ctrl),
        .stage(stage), .xfer_done(xfer_done));

    mem_port u_mem (.clk(clk), .reset_n(reset_n), .stage(stage), .xfer_done(xfer_done),
        .pc(pc), .alu_result(alu_result), .rs2_data(rs2_data), .ctrl(ctrl),
        .mem_rdata(mem_rdata), .mem_valid(mem_valid), .mem_instr(mem_instr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .instr(instr), .load_data(load_data));

    writeback u_wb (.clk(clk), .reset_n(reset_n), .stage(stage), .ctrl(ctrl), .imm(imm),
        .alu_result(alu_result), .load_data(load_data), .take_branch(take_branch),
        .pc(pc), .rd_we(rd_we), .rd_data(rd_data), .pc_out(pc_out));

endmodule

//--- src/writeback.sv
module writeback (
    input  logic           clk,
    input  logic           reset_n,
    input  rv_pkg::stage_t stage,
    input  rv_pkg::ctrl_t  ctrl,
    input  rv_pkg::word_t  imm,
    input  rv_pkg::word_t  alu_result,
    input  rv_pkg::word_t  load_data,
    input  logic           take_branch,
    output rv_pkg::word_t  pc,
    output logic           rd_we,
    output rv_pkg::word_t  rd_data,
    output rv_pkg::word_t  pc_out
);

    rv_pkg::word_t pc_next;
    rv_pkg::word_t pc_seq;     // pc + 4, also the link value

    assign pc_seq  = pc + rv_pkg::instr_step;
    assign rd_we   = ctrl.reg_write && (stage == rv_pkg::stage_wb);
    assign rd_data = ctrl.mem_read ? load_data : (ctrl.jump ? pc_seq : alu_result);
    assign pc_out  = pc;       // debug view

    always_comb begin
        if (take_branch)        pc_next = pc + imm;
        else if (ctrl.jump_reg) pc_next = {alu_result[31:1], 1'b0};   // jalr clears bit 0
        else if (ctrl.jump)     pc_next = pc + imm;                    // jal
        else                    pc_next = pc_seq;
    end

    // pc moves on the same edge as the register write
    always_ff @(posedge clk) begin
        if (!reset_n)
            pc <= '0;
        else if (stage == rv_pkg::stage_wb)
            pc <= pc_next;
    end

    assert property (@(posedge clk) disable iff (!reset_n) pc[1:0] == 2'b00);

endmodule

//--- src/mem_port.sv
module mem_port (
    input  logic           clk,
    input  logic           reset_n,
    input  rv_pkg::stage_t stage,
    input  logic           xfer_done,
    input  rv_pkg::word_t  pc,
    input  rv_pkg::word_t  alu_result,
    input  rv_pkg::word_t  rs2_data,
    input  rv_pkg::ctrl_t  ctrl,
    input  rv_pkg::word_t  mem_rdata,
    output logic           mem_valid,
    output logic           mem_instr,
    output rv_pkg::word_t  mem_addr,
    output rv_pkg::word_t  mem_wdata,
    output logic [3:0]     mem_wstrb,
    output rv_pkg::word_t  instr,
    output rv_pkg::word_t  load_data
);

    logic is_fetch;
    logic is_store;

    assign is_fetch = (stage == rv_pkg::stage_if);
    assign is_store = (stage == rv_pkg::stage_mem) && ctrl.mem_write;

    // request is a level, held stable until ready
    assign mem_valid = is_fetch || (stage == rv_pkg::stage_mem);
    assign mem_instr = is_fetch;
    assign mem_addr  = is_fetch ? pc : ((stage == rv_pkg::stage_mem) ? alu_result : '0);
    assign mem_wdata = is_store ? rs2_data : '0;
    assign mem_wstrb = is_store ? 4'b1111 : 4'b0000;   // word store or read

    // instruction reg, cleared so decode starts from a no-op opcode
    always_ff @(posedge clk) begin
        if (!reset_n)
            instr <= '0;
        else if (xfer_done && is_fetch)
            instr <= mem_rdata;
    end

    always_ff @(posedge clk) begin
        if (xfer_done && !is_fetch) load_data <= mem_rdata;   // load result
    end

    // pending request holds still until the transfer completes
    assert property (@(posedge clk) disable iff (!reset_n)
        (mem_valid && !xfer_done) |=> (mem_valid && $stable(mem_addr) && $stable(mem_wdata)
            && $stable(mem_wstrb) && $stable(mem_instr)));

endmodule

//--- src/stage_ctrl.sv
module stage_ctrl (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           mem_ready,
    input  rv_pkg::ctrl_t  ctrl,
    output rv_pkg::stage_t stage,
    output logic           xfer_done
);

    rv_pkg::stage_t stage_next;

    // handshake completes in the two bus stages only
    assign xfer_done = mem_ready && (stage == rv_pkg::stage_if || stage == rv_pkg::stage_mem);

    always_comb begin
        stage_next = stage;     // hold while waiting on ready
        case (stage)
            rv_pkg::stage_if:  if (xfer_done) stage_next = rv_pkg::stage_ex;
            rv_pkg::stage_ex: begin
                if (ctrl.mem_read || ctrl.mem_write)
                    stage_next = rv_pkg::stage_mem;
                else
                    stage_next = rv_pkg::stage_wb;    // skip memory
            end
            rv_pkg::stage_mem: if (xfer_done) stage_next = rv_pkg::stage_wb;
            default:           stage_next = rv_pkg::stage_if;    // wb is one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            stage <= rv_pkg::stage_if;
        else
            stage <= stage_next;
    end

    // memory stage only ever holds a load or a store
    assert property (@(posedge clk) disable iff (!reset_n)
        (stage == rv_pkg::stage_mem) |-> (ctrl.mem_read || ctrl.mem_write));

endmodule

//--- src/regfile.sv
module regfile (
    input  logic              clk,
    input  logic              reset_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  logic              rd_we,
    input  rv_pkg::word_t     rd_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    rv_pkg::word_t regs [32];

    // x0 may be written, reads always give zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) rd_we |-> !$isunknown(rd_addr));

endmodule

//--- src/exec_unit.sv
module exec_unit (
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t imm,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    input  logic [2:0]    funct3,
    output rv_pkg::word_t alu_result,
    output logic          take_branch
);

    rv_pkg::word_t in1;
    rv_pkg::word_t in2;
    logic [4:0]    shamt;
    logic          cond;      // raw branch condition

    // ------------------------------------------------------------------
    // operand muxes
    // ------------------------------------------------------------------
    always_comb begin
        case (ctrl.in1_sel)
            rv_pkg::in1_rs1: in1 = rs1_data;
            rv_pkg::in1_pc:  in1 = pc;        // auipc
            default:         in1 = '0;        // lui
        endcase
    end

    assign in2   = ctrl.in2_rs2 ? rs2_data : imm;
    assign shamt = in2[4:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_add:  alu_result = in1 + in2;
            rv_pkg::alu_sub:  alu_result = in1 - in2;
            rv_pkg::alu_sll:  alu_result = in1 << shamt;
            rv_pkg::alu_slt:  alu_result = {31'b0, $signed(in1) < $signed(in2)};
            rv_pkg::alu_sltu: alu_result = {31'b0, in1 < in2};
            rv_pkg::alu_xor:  alu_result = in1 ^ in2;
            rv_pkg::alu_srl:  alu_result = in1 >> shamt;
            rv_pkg::alu_sra:  alu_result = $signed(in1) >>> shamt;
            rv_pkg::alu_or:   alu_result = in1 | in2;
            rv_pkg::alu_and:  alu_result = in1 & in2;
            default:          alu_result = '0;
        endcase
    end

    // branch compare always on the two registers
    always_comb begin
        case (funct3)
            3'b000:  cond = (rs1_data == rs2_data);                     // beq
            3'b001:  cond = (rs1_data != rs2_data);                     // bne
            3'b100:  cond = ($signed(rs1_data) <  $signed(rs2_data));   // blt
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));   // bge
            3'b110:  cond = (rs1_data <  rs2_data);                     // bltu
            3'b111:  cond = (rs1_data >= rs2_data);                     // bgeu
            default: cond = 1'b0;
        endcase
    end

    assign take_branch = ctrl.branch && cond;

endmodule

//--- src/decoder.sv
module decoder (
    input  rv_pkg::word_t instr,
    output rv_pkg::ctrl_t ctrl,
    output rv_pkg::word_t imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;              // instr[30] selects sub / sra
    rv_pkg::alu_op_t fn_op;       // op picked from funct3

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // addi has no alternate form, only srai does
    assign alt = instr[30] && (opcode == rv_pkg::op_reg || funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  fn_op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  fn_op = rv_pkg::alu_sll;
            3'b010:  fn_op = rv_pkg::alu_slt;
            3'b011:  fn_op = rv_pkg::alu_sltu;
            3'b100:  fn_op = rv_pkg::alu_xor;
            3'b101:  fn_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  fn_op = rv_pkg::alu_or;
            default: fn_op = rv_pkg::alu_and;
        endcase
    end

    // ------------------------------------------------------------------
    // control decode
    // ------------------------------------------------------------------
    always_comb begin
        ctrl         = '0;                  // undefined ops: no write, no mem
        ctrl.in1_sel = rv_pkg::in1_rs1;
        ctrl.alu_op  = rv_pkg::alu_add;     // address and link math
        case (opcode)
            rv_pkg::op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.in1_sel   = rv_pkg::in1_zero;
            end
            rv_pkg::op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.in1_sel   = rv_pkg::in1_pc;
            end
            rv_pkg::op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
            end
            rv_pkg::op_jalr: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jump_reg  = 1'b1;      // target = rs1 + imm
            end
            rv_pkg::op_branch: begin
                ctrl.branch  = 1'b1;
                ctrl.in2_rs2 = 1'b1;
                ctrl.alu_op  = rv_pkg::alu_sub;
            end
            rv_pkg::op_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            rv_pkg::op_store: ctrl.mem_write = 1'b1;
            rv_pkg::op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = fn_op;
            end
            rv_pkg::op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.in2_rs2   = 1'b1;
                ctrl.alu_op    = fn_op;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------
    // immediates
    // ------------------------------------------------------------------
    always_comb begin
        case (opcode)
            rv_pkg::op_lui, rv_pkg::op_auipc: imm = {instr[31:12], 12'b0};      // U
            rv_pkg::op_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            rv_pkg::op_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_pkg::op_store: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // S
            default: begin
                if (opcode == rv_pkg::op_imm && funct3[1:0] == 2'b01)
                    imm = {27'b0, instr[24:20]};            // shamt only
                else
                    imm = {{20{instr[31]}}, instr[31:20]};  // I
            end
        endcase
    end

    // full funct7 must be the alternate encoding, not just bit 30
    always_comb begin
        if (opcode == rv_pkg::op_reg &&
            (ctrl.alu_op == rv_pkg::alu_sub || ctrl.alu_op == rv_pkg::alu_sra))
            assert (funct7 == rv_pkg::funct7_alt)
                else $error("op_reg sub/sra with funct7 %b", funct7);
    end

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    // ------------------------------------------------------------------
    // widths and basic types
    // ------------------------------------------------------------------
    localparam int xlen       = 32;   // data and address width
    localparam int reg_addr_w = 5;    // 32 integer registers

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam word_t instr_step = 32'd4;   // pc increment per instruction

    // ------------------------------------------------------------------
    // rv32i major opcodes
    // ------------------------------------------------------------------
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam logic [6:0] funct7_alt = 7'b0100000;   // sub / sra / srai

    // alu operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // first alu operand source
    typedef enum logic [1:0] {
        in1_zero,   // lui
        in1_rs1,
        in1_pc      // auipc
    } in1_sel_t;

    // multi-cycle sequencer stages
    typedef enum logic [1:0] {
        stage_if,
        stage_ex,
        stage_mem,
        stage_wb
    } stage_t;

    // decoded control bundle, 13 bits
    typedef struct packed {
        logic     reg_write;
        logic     mem_write;
        logic     mem_read;
        logic     branch;
        logic     jump;       // jal and jalr
        logic     jump_reg;   // jalr only
        in1_sel_t in1_sel;
        logic     in2_rs2;    // 0 selects imm
        alu_op_t  alu_op;
    } ctrl_t;

endpackage
